/* common/la_consts.svh */
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

`define LA_XLEN    32
`define LA_RADDR_W 5
`define LA_NREGS   32
`define LA_SHAMT_W 5

//////////////////////////////////////////////////
// instruction fields

`define LA_OP6    31:26
`define LA_OP7    31:25
`define LA_OP_SUB 25:20
`define LA_OP_FN  19:15

`define LA_RD 4:0
`define LA_RJ 9:5
`define LA_RK 14:10

`define LA_SI12 21:10
`define LA_UI5  14:10
`define LA_SI20 24:5

//////////////////////////////////////////////////
// encodings of the kept instructions

`define LA_MAJ_ARITH 6'b000000
`define LA_MAJ_LU12I 6'b000101
`define LA_LU12I_W   7'b0001010

// low two bits belong to the 12-bit immediate
`define LA_SUB_SLTI   6'b1000??
`define LA_SUB_SLTUI  6'b1001??
`define LA_SUB_ADDI_W 6'b1010??
`define LA_SUB_ANDI   6'b1101??
`define LA_SUB_ORI    6'b1110??
`define LA_SUB_XORI   6'b1111??
`define LA_SUB_3R     6'b000001
`define LA_SUB_SHIFTI 6'b000100

`define LA_FN_ADD_W  5'b00000
`define LA_FN_SUB_W  5'b00010
`define LA_FN_SLT    5'b00100
`define LA_FN_SLTU   5'b00101
`define LA_FN_NOR    5'b01000
`define LA_FN_AND    5'b01001
`define LA_FN_OR     5'b01010
`define LA_FN_XOR    5'b01011
`define LA_FN_SLL_W  5'b01110
`define LA_FN_SRL_W  5'b01111
`define LA_FN_SRA_W  5'b10000
`define LA_FN_SLLI_W 5'b00001
`define LA_FN_SRLI_W 5'b01001
`define LA_FN_SRAI_W 5'b10001

`endif

/* common/la_pkg.sv */
package la_pkg;

  //////////////////////////////////////////////////
  // ALU operations

  typedef enum logic [3:0] {
    ALU_NOP  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_NOR  = 4'd8,
    ALU_SLL  = 4'd9,
    ALU_SRL  = 4'd10,
    ALU_SRA  = 4'd11,
    ALU_LUI  = 4'd12   // result is operand b, already shifted by the decoder
  } aluop_e;

  //////////////////////////////////////////////////
  // result classes

  // the class follows from the operation and only shows up in waveforms
  typedef enum logic [2:0] {
    SEL_NOP   = 3'd0,
    SEL_LOGIC = 3'd1,
    SEL_SHIFT = 3'd2,
    SEL_ARITH = 3'd3,
    SEL_MOVE  = 3'd4
  } alusel_e;

endpackage

/* src/dec_stage.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module dec_stage (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   inst_valid_i,
  input  logic [`LA_XLEN-1:0]    inst_i,
  input  logic [`LA_XLEN-1:0]    pc_i,
  output logic                   dec_valid_o,
  output logic                   dec_ill_o,
  output la_pkg::aluop_e         dec_aluop_o,
  output la_pkg::alusel_e        dec_alusel_o,
  output logic [`LA_RADDR_W-1:0] dec_rj_o,
  output logic [`LA_RADDR_W-1:0] dec_rk_o,
  output logic [`LA_RADDR_W-1:0] dec_rd_o,
  output logic                   dec_rj_read_o,
  output logic                   dec_rk_read_o,
  output logic                   dec_we_o,
  output logic [`LA_XLEN-1:0]    dec_imm_o,
  output logic [`LA_XLEN-1:0]    dec_pc_o
);

  import la_pkg::*;

  logic [11:0]            si12;
  logic [`LA_XLEN-1:0]    si12_sext;
  logic [`LA_XLEN-1:0]    si12_zext;
  logic [`LA_XLEN-1:0]    ui5_zext;
  logic [`LA_XLEN-1:0]    si20_hi;
  logic [`LA_RADDR_W-1:0] rd;

  aluop_e              aluop_c;
  alusel_e             alusel_c;
  logic                ill_c;
  logic                rj_read_c;
  logic                rk_read_c;
  logic [`LA_XLEN-1:0] imm_c;

  assign si12      = inst_i[`LA_SI12];
  assign si12_sext = {{(`LA_XLEN-12){si12[11]}}, si12};
  assign si12_zext = {{(`LA_XLEN-12){1'b0}}, si12};
  assign ui5_zext  = {{(`LA_XLEN-5){1'b0}}, inst_i[`LA_UI5]};
  assign si20_hi   = {inst_i[`LA_SI20], 12'b0};
  assign rd        = inst_i[`LA_RD];

  //////////////////////////////////////////////////
  // decode

  always_comb
  begin
    aluop_c   = ALU_NOP;
    rj_read_c = 1'b0;
    rk_read_c = 1'b0;
    imm_c     = '0;
    case (inst_i[`LA_OP6])
      `LA_MAJ_LU12I:
      begin
        if (inst_i[`LA_OP7] == `LA_LU12I_W) // bit 25 set would be LU32I.D
        begin
          aluop_c = ALU_LUI;
          imm_c   = si20_hi;
        end
      end
      `LA_MAJ_ARITH:
      begin
        rj_read_c = 1'b1;
        imm_c     = si12_sext;
        casez (inst_i[`LA_OP_SUB])
          `LA_SUB_SLTI:   aluop_c = ALU_SLT;
          `LA_SUB_SLTUI:  aluop_c = ALU_SLTU; // unsigned compare against the sign-extended value
          `LA_SUB_ADDI_W: aluop_c = ALU_ADD;
          `LA_SUB_ANDI:
          begin
            aluop_c = ALU_AND;
            imm_c   = si12_zext;
          end
          `LA_SUB_ORI:
          begin
            aluop_c = ALU_OR;
            imm_c   = si12_zext;
          end
          `LA_SUB_XORI:
          begin
            aluop_c = ALU_XOR;
            imm_c   = si12_zext;
          end
          `LA_SUB_3R:
          begin
            rk_read_c = 1'b1;
            case (inst_i[`LA_OP_FN])
              `LA_FN_ADD_W: aluop_c = ALU_ADD;
              `LA_FN_SUB_W: aluop_c = ALU_SUB;
              `LA_FN_SLT:   aluop_c = ALU_SLT;
              `LA_FN_SLTU:  aluop_c = ALU_SLTU;
              `LA_FN_NOR:   aluop_c = ALU_NOR;
              `LA_FN_AND:   aluop_c = ALU_AND;
              `LA_FN_OR:    aluop_c = ALU_OR;
              `LA_FN_XOR:   aluop_c = ALU_XOR;
              `LA_FN_SLL_W: aluop_c = ALU_SLL;
              `LA_FN_SRL_W: aluop_c = ALU_SRL;
              `LA_FN_SRA_W: aluop_c = ALU_SRA;
              default:      aluop_c = ALU_NOP;
            endcase
          end
          `LA_SUB_SHIFTI:
          begin
            imm_c = ui5_zext;
            case (inst_i[`LA_OP_FN])
              `LA_FN_SLLI_W: aluop_c = ALU_SLL;
              `LA_FN_SRLI_W: aluop_c = ALU_SRL;
              `LA_FN_SRAI_W: aluop_c = ALU_SRA;
              default:       aluop_c = ALU_NOP;
            endcase
          end
          default: aluop_c = ALU_NOP;
        endcase
      end
      default: aluop_c = ALU_NOP;
    endcase
    ill_c = (aluop_c == ALU_NOP); // every kept instruction has a real operation
  end

  always_comb
  begin
    case (aluop_c)
      ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU:  alusel_c = SEL_ARITH;
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:   alusel_c = SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA:          alusel_c = SEL_SHIFT;
      ALU_LUI:                            alusel_c = SEL_MOVE;
      default:                            alusel_c = SEL_NOP;
    endcase
  end

  //////////////////////////////////////////////////
  // decode register

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      dec_valid_o <= 1'b0;
      dec_ill_o   <= 1'b0;
      dec_we_o    <= 1'b0;
    end
    else
    begin
      dec_valid_o <= inst_valid_i;
      dec_ill_o   <= inst_valid_i & ill_c;
      dec_we_o    <= inst_valid_i & ~ill_c & (rd != '0); // r0 is never written
    end
  end

  always_ff @(posedge clk)
  begin
    dec_aluop_o   <= aluop_c;
    dec_alusel_o  <= alusel_c;
    dec_rj_o      <= inst_i[`LA_RJ];
    dec_rk_o      <= inst_i[`LA_RK];
    dec_rd_o      <= rd;
    dec_rj_read_o <= rj_read_c;
    dec_rk_read_o <= rk_read_c;
    dec_imm_o     <= imm_c;
    dec_pc_o      <= pc_i;
  end

endmodule

/* src/regfile.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module regfile (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`LA_RADDR_W-1:0] ra1_i,
  input  logic [`LA_RADDR_W-1:0] ra2_i,
  input  logic                   we_i,
  input  logic [`LA_RADDR_W-1:0] wa_i,
  input  logic [`LA_XLEN-1:0]    wd_i,
  output logic [`LA_XLEN-1:0]    rd1_o,
  output logic [`LA_XLEN-1:0]    rd2_o
);

  // r0 has no storage
  logic [`LA_XLEN-1:0] regs [1:`LA_NREGS-1];

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      for (int i = 1; i < `LA_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we_i && (wa_i != '0))
      regs[wa_i] <= wd_i;
  end

  // no bypass here, opnd_stage forwards the word being written
  assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
  assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

/* src/opnd_stage.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module opnd_stage (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   dec_valid_i,
  input  logic                   dec_ill_i,
  input  la_pkg::aluop_e         dec_aluop_i,
  input  logic [`LA_RADDR_W-1:0] dec_rj_i,
  input  logic [`LA_RADDR_W-1:0] dec_rk_i,
  input  logic [`LA_RADDR_W-1:0] dec_rd_i,
  input  logic                   dec_rj_read_i,
  input  logic                   dec_rk_read_i,
  input  logic                   dec_we_i,
  input  logic [`LA_XLEN-1:0]    dec_imm_i,
  input  logic [`LA_XLEN-1:0]    dec_pc_i,
  input  logic [`LA_XLEN-1:0]    rf_rd1_i,
  input  logic [`LA_XLEN-1:0]    rf_rd2_i,
  input  logic                   ex_we_i,
  input  logic [`LA_RADDR_W-1:0] ex_addr_i,
  input  logic [`LA_XLEN-1:0]    ex_data_i,
  input  logic                   wb_we_i,
  input  logic [`LA_RADDR_W-1:0] wb_addr_i,
  input  logic [`LA_XLEN-1:0]    wb_data_i,
  output logic [`LA_RADDR_W-1:0] rf_ra1_o,
  output logic [`LA_RADDR_W-1:0] rf_ra2_o,
  output logic                   op_valid_o,
  output logic                   op_ill_o,
  output la_pkg::aluop_e         op_aluop_o,
  output logic [`LA_XLEN-1:0]    op_a_o,
  output logic [`LA_XLEN-1:0]    op_b_o,
  output logic [`LA_RADDR_W-1:0] op_rd_o,
  output logic                   op_we_o,
  output logic [`LA_XLEN-1:0]    op_pc_o
);

  logic [`LA_XLEN-1:0] opnd_a;
  logic [`LA_XLEN-1:0] opnd_b;

  // newest producer wins, exec result first, then the writeback register
  function automatic logic [`LA_XLEN-1:0] fwd_value(input logic [`LA_RADDR_W-1:0] ra,
                                                    input logic [`LA_XLEN-1:0]    rf_val);
    if (ra == '0)
      return '0;
    else if (ex_we_i && (ex_addr_i == ra))
      return ex_data_i;
    else if (wb_we_i && (wb_addr_i == ra))
      return wb_data_i;
    else
      return rf_val;
  endfunction

  assign rf_ra1_o = dec_rj_i;
  assign rf_ra2_o = dec_rk_i;

  assign opnd_a = dec_rj_read_i ? fwd_value(dec_rj_i, rf_rd1_i) : '0; // zero for LU12I.W
  assign opnd_b = dec_rk_read_i ? fwd_value(dec_rk_i, rf_rd2_i) : dec_imm_i;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      op_valid_o <= 1'b0;
      op_ill_o   <= 1'b0;
      op_we_o    <= 1'b0;
    end
    else
    begin
      op_valid_o <= dec_valid_i;
      op_ill_o   <= dec_ill_i;
      op_we_o    <= dec_we_i;
    end
  end

  always_ff @(posedge clk)
  begin
    op_aluop_o <= dec_aluop_i;
    op_a_o     <= opnd_a;
    op_b_o     <= opnd_b;
    op_rd_o    <= dec_rd_i;
    op_pc_o    <= dec_pc_i;
  end

endmodule

/* src/exec_stage.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module exec_stage (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   op_valid_i,
  input  logic                   op_ill_i,
  input  la_pkg::aluop_e         op_aluop_i,
  input  logic [`LA_XLEN-1:0]    op_a_i,
  input  logic [`LA_XLEN-1:0]    op_b_i,
  input  logic [`LA_RADDR_W-1:0] op_rd_i,
  input  logic                   op_we_i,
  input  logic [`LA_XLEN-1:0]    op_pc_i,
  output logic                   ex_we_o,
  output logic [`LA_RADDR_W-1:0] ex_addr_o,
  output logic [`LA_XLEN-1:0]    ex_data_o,
  output logic                   wb_valid_o,
  output logic                   wb_ill_o,
  output logic                   wb_we_o,
  output logic [`LA_RADDR_W-1:0] wb_addr_o,
  output logic [`LA_XLEN-1:0]    wb_data_o,
  output logic [`LA_XLEN-1:0]    wb_pc_o
);

  import la_pkg::*;

  logic [`LA_SHAMT_W-1:0] shamt;
  logic [`LA_XLEN-1:0]    alu_res;

  assign shamt = op_b_i[`LA_SHAMT_W-1:0]; // upper bits of rk are ignored

  //////////////////////////////////////////////////
  // ALU

  always_comb
  begin
    case (op_aluop_i)
      ALU_ADD:  alu_res = op_a_i + op_b_i;
      ALU_SUB:  alu_res = op_a_i - op_b_i;
      ALU_SLT:  alu_res = {{(`LA_XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      ALU_SLTU: alu_res = {{(`LA_XLEN-1){1'b0}}, op_a_i < op_b_i};
      ALU_AND:  alu_res = op_a_i & op_b_i;
      ALU_OR:   alu_res = op_a_i | op_b_i;
      ALU_XOR:  alu_res = op_a_i ^ op_b_i;
      ALU_NOR:  alu_res = ~(op_a_i | op_b_i);
      ALU_SLL:  alu_res = op_a_i << shamt;
      ALU_SRL:  alu_res = op_a_i >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(op_a_i) >>> shamt);
      ALU_LUI:  alu_res = op_b_i;
      default:  alu_res = '0; // illegal encodings retire with zero
    endcase
  end

  // forward path into opnd_stage
  assign ex_we_o   = op_we_i;
  assign ex_addr_o = op_rd_i;
  assign ex_data_o = alu_res;

  //////////////////////////////////////////////////
  // writeback register

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wb_valid_o <= 1'b0;
      wb_ill_o   <= 1'b0;
      wb_we_o    <= 1'b0;
    end
    else
    begin
      wb_valid_o <= op_valid_i;
      wb_ill_o   <= op_ill_i;
      wb_we_o    <= op_we_i;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_addr_o <= op_rd_i;
    wb_data_o <= alu_res;
    wb_pc_o   <= op_pc_i;
  end

endmodule

/* src/la_int_pipe.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module la_int_pipe (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   inst_valid_i,
  input  logic [`LA_XLEN-1:0]    inst_i,
  input  logic [`LA_XLEN-1:0]    pc_i,
  output logic                   wb_valid_o,
  output logic                   wb_we_o,
  output logic                   wb_ill_o,
  output logic [`LA_RADDR_W-1:0] wb_addr_o,
  output logic [`LA_XLEN-1:0]    wb_data_o,
  output logic [`LA_XLEN-1:0]    wb_pc_o
);

  import la_pkg::*;

  // decode to operand stage
  logic                   dec_valid;
  logic                   dec_ill;
  aluop_e                 dec_aluop;
  logic [`LA_RADDR_W-1:0] dec_rj;
  logic [`LA_RADDR_W-1:0] dec_rk;
  logic [`LA_RADDR_W-1:0] dec_rd;
  logic                   dec_rj_read;
  logic                   dec_rk_read;
  logic                   dec_we;
  logic [`LA_XLEN-1:0]    dec_imm;
  logic [`LA_XLEN-1:0]    dec_pc;

  // operand stage to exec
  logic                   op_valid;
  logic                   op_ill;
  aluop_e                 op_aluop;
  logic [`LA_XLEN-1:0]    op_a;
  logic [`LA_XLEN-1:0]    op_b;
  logic [`LA_RADDR_W-1:0] op_rd;
  logic                   op_we;
  logic [`LA_XLEN-1:0]    op_pc;

  logic [`LA_RADDR_W-1:0] rf_ra1;
  logic [`LA_RADDR_W-1:0] rf_ra2;
  logic [`LA_XLEN-1:0]    rf_rd1;
  logic [`LA_XLEN-1:0]    rf_rd2;

  logic                   ex_we;
  logic [`LA_RADDR_W-1:0] ex_addr;
  logic [`LA_XLEN-1:0]    ex_data;

  dec_stage u_dec_stage (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .dec_valid_o   (dec_valid),
    .dec_ill_o     (dec_ill),
    .dec_aluop_o   (dec_aluop),
    .dec_alusel_o  (),           // result class is only watched in waveforms
    .dec_rj_o      (dec_rj),
    .dec_rk_o      (dec_rk),
    .dec_rd_o      (dec_rd),
    .dec_rj_read_o (dec_rj_read),
    .dec_rk_read_o (dec_rk_read),
    .dec_we_o      (dec_we),
    .dec_imm_o     (dec_imm),
    .dec_pc_o      (dec_pc)
  );

  regfile u_regfile (
    .clk   (clk),
    .rst_i (rst_i),
    .ra1_i (rf_ra1),
    .ra2_i (rf_ra2),
    .we_i  (wb_we_o),    // the retiring instruction writes back
    .wa_i  (wb_addr_o),
    .wd_i  (wb_data_o),
    .rd1_o (rf_rd1),
    .rd2_o (rf_rd2)
  );

  opnd_stage u_opnd_stage (
    .clk           (clk),
    .rst_i         (rst_i),
    .dec_valid_i   (dec_valid),
    .dec_ill_i     (dec_ill),
    .dec_aluop_i   (dec_aluop),
    .dec_rj_i      (dec_rj),
    .dec_rk_i      (dec_rk),
    .dec_rd_i      (dec_rd),
    .dec_rj_read_i (dec_rj_read),
    .dec_rk_read_i (dec_rk_read),
    .dec_we_i      (dec_we),
    .dec_imm_i     (dec_imm),
    .dec_pc_i      (dec_pc),
    .rf_rd1_i      (rf_rd1),
    .rf_rd2_i      (rf_rd2),
    .ex_we_i       (ex_we),
    .ex_addr_i     (ex_addr),
    .ex_data_i     (ex_data),
    .wb_we_i       (wb_we_o),
    .wb_addr_i     (wb_addr_o),
    .wb_data_i     (wb_data_o),
    .rf_ra1_o      (rf_ra1),
    .rf_ra2_o      (rf_ra2),
    .op_valid_o    (op_valid),
    .op_ill_o      (op_ill),
    .op_aluop_o    (op_aluop),
    .op_a_o        (op_a),
    .op_b_o        (op_b),
    .op_rd_o       (op_rd),
    .op_we_o       (op_we),
    .op_pc_o       (op_pc)
  );

  exec_stage u_exec_stage (
    .clk        (clk),
    .rst_i      (rst_i),
    .op_valid_i (op_valid),
    .op_ill_i   (op_ill),
    .op_aluop_i (op_aluop),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .op_rd_i    (op_rd),
    .op_we_i    (op_we),
    .op_pc_i    (op_pc),
    .ex_we_o    (ex_we),
    .ex_addr_o  (ex_addr),
    .ex_data_o  (ex_data),
    .wb_valid_o (wb_valid_o),
    .wb_ill_o   (wb_ill_o),
    .wb_we_o    (wb_we_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o),
    .wb_pc_o    (wb_pc_o)
  );

endmodule

/* dv/wb_checker.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module wb_checker (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   inst_valid_i,
  input  logic [`LA_XLEN-1:0]    inst_i,
  input  logic [`LA_XLEN-1:0]    pc_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_we_i,
  input  logic                   wb_ill_i,
  input  logic [`LA_RADDR_W-1:0] wb_addr_i,
  input  logic [`LA_XLEN-1:0]    wb_data_i,
  input  logic [`LA_XLEN-1:0]    wb_pc_i,
  output int                     checks_o,
  output int                     errors_o,
  output int                     pending_o
);

  typedef struct packed {
    logic [31:0]            due;
    logic [`LA_XLEN-1:0]    pc;
    logic [`LA_XLEN-1:0]    data;
    logic [`LA_RADDR_W-1:0] addr;
    logic                   we;
    logic                   ill;
  } retire_t;

  retire_t             exp_q[$];
  logic [`LA_XLEN-1:0] shadow [0:`LA_NREGS-1]; // architectural state in program order
  logic [31:0]         cycle;

  // LoongArch32 semantics of the kept instructions, returns 0 for anything else
  function automatic logic ref_exec(input logic [31:0] inst, input logic [31:0] a,
                                    input logic [31:0] b, output logic [31:0] res);
    logic [31:0] sext;
    logic [31:0] zext;
    logic        legal;
    sext  = {{20{inst[21]}}, inst[21:10]};
    zext  = {20'b0, inst[21:10]};
    legal = 1'b1;
    res   = '0;
    if (inst[31:25] == 7'h0a)
      res = {inst[24:5], 12'b0}; // LU12I.W
    else
    begin
      case (inst[31:22])
        10'h008: res = {31'b0, $signed(a) < $signed(sext)};
        10'h009: res = {31'b0, a < sext};
        10'h00a: res = a + sext;
        10'h00d: res = a & zext;
        10'h00e: res = a | zext;
        10'h00f: res = a ^ zext;
        default:
        begin
          case (inst[31:15])
            17'h00020: res = a + b;
            17'h00022: res = a - b;
            17'h00024: res = {31'b0, $signed(a) < $signed(b)};
            17'h00025: res = {31'b0, a < b};
            17'h00028: res = ~(a | b);
            17'h00029: res = a & b;
            17'h0002a: res = a | b;
            17'h0002b: res = a ^ b;
            17'h0002e: res = a << b[4:0];
            17'h0002f: res = a >> b[4:0];
            17'h00030: res = $unsigned($signed(a) >>> b[4:0]);
            17'h00081: res = a << inst[14:10];
            17'h00089: res = a >> inst[14:10];
            17'h00091: res = $unsigned($signed(a) >>> inst[14:10]);
            default:   legal = 1'b0;
          endcase
        end
      endcase
    end
    return legal;
  endfunction

  task automatic compare_retire(input retire_t item);
    logic bad;
    bad = 1'b0;
    if (wb_pc_i !== item.pc)
    begin
      $display("Error %0t: retired pc %08h, expected %08h", $time, wb_pc_i, item.pc);
      bad = 1'b1;
    end
    if ((wb_ill_i !== item.ill) || (wb_we_i !== item.we))
    begin
      $display("Error %0t: pc %08h ill %b we %b, expected ill %b we %b", $time,
               item.pc, wb_ill_i, wb_we_i, item.ill, item.we);
      bad = 1'b1;
    end
    if (!item.ill && ((wb_data_i !== item.data) || (wb_addr_i !== item.addr)))
    begin
      $display("Error %0t: pc %08h wrote r%0d = %08h, expected r%0d = %08h", $time,
               item.pc, wb_addr_i, wb_data_i, item.addr, item.data);
      bad = 1'b1;
    end
    checks_o++;
    if (bad)
      errors_o++;
  endtask

  //////////////////////////////////////////////////
  // issue and retire tracking

  always @(posedge clk)
  begin
    retire_t     item;
    logic [31:0] res;
    logic        legal;
    if (rst_i)
    begin
      cycle = '0;
      exp_q.delete();
      for (int i = 0; i < `LA_NREGS; i++)
        shadow[i] = '0;
      checks_o = 0;
      errors_o = 0;
    end
    else
    begin
      cycle = cycle + 1;
      if ((exp_q.size() != 0) && (exp_q[0].due == cycle))
      begin
        item = exp_q.pop_front();
        if (!wb_valid_i)
        begin
          $display("instruction at pc %08h did not retire 3 cycles after issue", item.pc);
          errors_o++;
        end
        else
          compare_retire(item);
      end
      else if (wb_valid_i)
      begin
        $display("unexpected retirement of pc %08h with nothing outstanding", wb_pc_i);
        errors_o++;
      end
      if (inst_valid_i)
      begin
        legal     = ref_exec(inst_i, shadow[inst_i[`LA_RJ]], shadow[inst_i[`LA_RK]], res);
        item.due  = cycle + 3; // fixed pipeline latency
        item.pc   = pc_i;
        item.data = res;
        item.addr = inst_i[`LA_RD];
        item.ill  = ~legal;
        item.we   = legal && (inst_i[`LA_RD] != 5'd0);
        if (item.we)
          shadow[item.addr] = res;
        exp_q.push_back(item);
      end
    end
    pending_o = exp_q.size();
  end

endmodule

/* dv/tb_la_int_pipe.sv */
`timescale 1ns/100ps
`include "la_consts.svh"

module tb_la_int_pipe;

  localparam logic [16:0] OP_ADD_W  = 17'h00020;
  localparam logic [16:0] OP_SUB_W  = 17'h00022;
  localparam logic [16:0] OP_SLT    = 17'h00024;
  localparam logic [16:0] OP_SLTU   = 17'h00025;
  localparam logic [16:0] OP_NOR    = 17'h00028;
  localparam logic [16:0] OP_AND    = 17'h00029;
  localparam logic [16:0] OP_OR     = 17'h0002a;
  localparam logic [16:0] OP_XOR    = 17'h0002b;
  localparam logic [16:0] OP_SLL_W  = 17'h0002e;
  localparam logic [16:0] OP_SRL_W  = 17'h0002f;
  localparam logic [16:0] OP_SRA_W  = 17'h00030;
  localparam logic [16:0] OP_SLLI_W = 17'h00081;
  localparam logic [16:0] OP_SRLI_W = 17'h00089;
  localparam logic [16:0] OP_SRAI_W = 17'h00091;
  localparam logic [9:0]  OP_SLTI   = 10'h008;
  localparam logic [9:0]  OP_SLTUI  = 10'h009;
  localparam logic [9:0]  OP_ADDI_W = 10'h00a;
  localparam logic [9:0]  OP_ANDI   = 10'h00d;
  localparam logic [9:0]  OP_ORI    = 10'h00e;
  localparam logic [9:0]  OP_XORI   = 10'h00f;
  localparam logic [6:0]  OP_LU12I  = 7'h0a;
  localparam int          DRAIN_LIMIT = 20;

  logic                   clk;
  logic                   rst_i;
  logic                   inst_valid_i;
  logic [`LA_XLEN-1:0]    inst_i;
  logic [`LA_XLEN-1:0]    pc_i;
  logic                   wb_valid_o;
  logic                   wb_we_o;
  logic                   wb_ill_o;
  logic [`LA_RADDR_W-1:0] wb_addr_o;
  logic [`LA_XLEN-1:0]    wb_data_o;
  logic [`LA_XLEN-1:0]    wb_pc_o;
  int                     checks;
  int                     errors;
  int                     pending;
  int                     last_checks;
  int                     last_errors;
  logic                   timed_out;
  logic [`LA_XLEN-1:0]    next_pc;
  integer                 seed;

  always #5 clk = ~clk;

  la_int_pipe u_la_int_pipe (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .wb_valid_o   (wb_valid_o),
    .wb_we_o      (wb_we_o),
    .wb_ill_o     (wb_ill_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o),
    .wb_pc_o      (wb_pc_o)
  );

  wb_checker u_wb_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .wb_valid_i   (wb_valid_o),
    .wb_we_i      (wb_we_o),
    .wb_ill_i     (wb_ill_o),
    .wb_addr_i    (wb_addr_o),
    .wb_data_i    (wb_data_o),
    .wb_pc_i      (wb_pc_o),
    .checks_o     (checks),
    .errors_o     (errors),
    .pending_o    (pending)
  );

  //////////////////////////////////////////////////
  // instruction encoders

  function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                         input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd}; // shift immediates sit in the rk slot
  endfunction

  function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic logic [31:0] enc_lu12i(input logic [19:0] imm, input logic [4:0] rd);
    return {OP_LU12I, imm, rd};
  endfunction

  // registers stay in r0..r15 so that dependences are frequent
  function automatic logic [31:0] random_inst(input logic [31:0] r1, input logic [31:0] r2);
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] imm;
    rd  = {1'b0, r2[3:0]};
    rj  = {1'b0, r2[7:4]};
    rk  = {1'b0, r2[11:8]};
    imm = r2[23:12];
    case (r1 % 21)
      0:       return enc_3r(OP_ADD_W, rk, rj, rd);
      1:       return enc_3r(OP_SUB_W, rk, rj, rd);
      2:       return enc_3r(OP_SLT, rk, rj, rd);
      3:       return enc_3r(OP_SLTU, rk, rj, rd);
      4:       return enc_3r(OP_AND, rk, rj, rd);
      5:       return enc_3r(OP_OR, rk, rj, rd);
      6:       return enc_3r(OP_XOR, rk, rj, rd);
      7:       return enc_3r(OP_NOR, rk, rj, rd);
      8:       return enc_3r(OP_SLL_W, rk, rj, rd);
      9:       return enc_3r(OP_SRL_W, rk, rj, rd);
      10:      return enc_3r(OP_SRA_W, rk, rj, rd);
      11:      return enc_3r(OP_SLLI_W, imm[4:0], rj, rd);
      12:      return enc_3r(OP_SRLI_W, imm[4:0], rj, rd);
      13:      return enc_3r(OP_SRAI_W, imm[4:0], rj, rd);
      14:      return enc_ri12(OP_ADDI_W, imm, rj, rd);
      15:      return enc_ri12(OP_SLTI, imm, rj, rd);
      16:      return enc_ri12(OP_SLTUI, imm, rj, rd);
      17:      return enc_ri12(OP_ANDI, imm, rj, rd);
      18:      return enc_ri12(OP_ORI, imm, rj, rd);
      19:      return enc_ri12(OP_XORI, imm, rj, rd);
      default: return enc_lu12i({r2[31:24], imm}, rd);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks

  task automatic issue_inst(input logic [31:0] inst);
    @(negedge clk);
    inst_valid_i = 1'b1;
    inst_i       = inst;
    pc_i         = next_pc;
    next_pc      = next_pc + 32'd4;
  endtask

  task automatic drain_pipe();
    int n;
    @(negedge clk);
    inst_valid_i = 1'b0;
    n = 0;
    while ((pending != 0) && (n < DRAIN_LIMIT))
    begin
      @(negedge clk);
      n++;
    end
    if (pending != 0)
    begin
      $display("timeout: %0d instructions never retired within %0d cycles", pending, DRAIN_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    drain_pipe();
    $display("test %s %0d retired, %0d errors", name, checks - last_checks,
             errors - last_errors);
    last_checks = checks;
    last_errors = errors;
  endtask

  initial
  begin
    logic [31:0] r1;
    logic [31:0] r2;
    clk          = 1'b0;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    next_pc      = 32'h1c00_0000;
    seed         = 18;
    last_checks  = 0;
    last_errors  = 0;
    timed_out    = 1'b0;
    repeat (3) @(negedge clk);
    rst_i = 1'b0;

    // quiet pipeline first, any retirement here is flagged by the checker
    repeat (6) @(negedge clk);
    issue_inst(enc_3r(OP_ADD_W, 5'd0, 5'd7, 5'd1));
    issue_inst(enc_3r(OP_ADD_W, 5'd9, 5'd0, 5'd2));
    end_test("reset");

    issue_inst(enc_ri12(OP_ADDI_W, 12'hfff, 5'd0, 5'd1));
    issue_inst(enc_ri12(OP_ADDI_W, 12'h7ff, 5'd0, 5'd2));
    issue_inst(enc_ri12(OP_SLTI, 12'h800, 5'd0, 5'd3));
    issue_inst(enc_ri12(OP_SLTI, 12'h000, 5'd1, 5'd4));
    issue_inst(enc_ri12(OP_SLTUI, 12'hfff, 5'd0, 5'd5));
    issue_inst(enc_ri12(OP_SLTUI, 12'hfff, 5'd1, 5'd6));
    issue_inst(enc_ri12(OP_ANDI, 12'hfff, 5'd1, 5'd7));
    issue_inst(enc_ri12(OP_SLTUI, 12'hfff, 5'd7, 5'd12)); // 0xfff is below 0xffffffff only
    issue_inst(enc_ri12(OP_ORI, 12'h800, 5'd0, 5'd8));
    issue_inst(enc_ri12(OP_XORI, 12'h8f0, 5'd1, 5'd9));
    issue_inst(enc_lu12i(20'h12345, 5'd10));
    issue_inst(enc_lu12i(20'hfffff, 5'd11));
    issue_inst(enc_ri12(OP_ORI, 12'habc, 5'd11, 5'd11));
    end_test("imm");

    issue_inst(enc_lu12i(20'h80000, 5'd1));
    issue_inst(enc_ri12(OP_ORI, 12'h123, 5'd1, 5'd1));
    issue_inst(enc_ri12(OP_ADDI_W, 12'hffb, 5'd0, 5'd2));
    issue_inst(enc_ri12(OP_ADDI_W, 12'd37, 5'd0, 5'd3)); // only 5 of 37 counts as shift
    issue_inst(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd4));
    issue_inst(enc_3r(OP_SUB_W, 5'd2, 5'd1, 5'd5));
    issue_inst(enc_3r(OP_SLT, 5'd3, 5'd1, 5'd6));
    issue_inst(enc_3r(OP_SLTU, 5'd3, 5'd1, 5'd7));
    issue_inst(enc_3r(OP_AND, 5'd2, 5'd1, 5'd8));
    issue_inst(enc_3r(OP_OR, 5'd2, 5'd1, 5'd9));
    issue_inst(enc_3r(OP_XOR, 5'd2, 5'd1, 5'd10));
    issue_inst(enc_3r(OP_NOR, 5'd2, 5'd1, 5'd12));
    issue_inst(enc_3r(OP_SLL_W, 5'd3, 5'd1, 5'd13));
    issue_inst(enc_3r(OP_SRL_W, 5'd3, 5'd1, 5'd14));
    issue_inst(enc_3r(OP_SRA_W, 5'd3, 5'd1, 5'd15));
    issue_inst(enc_3r(OP_SLLI_W, 5'd31, 5'd1, 5'd16));
    issue_inst(enc_3r(OP_SRLI_W, 5'd4, 5'd1, 5'd17));
    issue_inst(enc_3r(OP_SRAI_W, 5'd4, 5'd1, 5'd18));
    end_test("regreg");

    issue_inst(enc_ri12(OP_ADDI_W, 12'd100, 5'd0, 5'd1));
    issue_inst(enc_3r(OP_ADD_W, 5'd1, 5'd1, 5'd2));
    issue_inst(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd3));
    issue_inst(enc_3r(OP_ADD_W, 5'd3, 5'd1, 5'd4));
    issue_inst(enc_ri12(OP_ADDI_W, 12'd7, 5'd0, 5'd1));
    issue_inst(enc_ri12(OP_ADDI_W, 12'd9, 5'd0, 5'd1));
    issue_inst(enc_3r(OP_SUB_W, 5'd0, 5'd1, 5'd5)); // two writers in flight, newest wins
    issue_inst(enc_ri12(OP_ADDI_W, 12'd8, 5'd1, 5'd1));
    issue_inst(enc_3r(OP_ADD_W, 5'd1, 5'd5, 5'd6));
    end_test("forward");

    issue_inst(enc_ri12(OP_ADDI_W, 12'd55, 5'd0, 5'd2));
    issue_inst(enc_ri12(OP_ADDI_W, 12'd5, 5'd2, 5'd0));
    issue_inst(enc_3r(OP_ADD_W, 5'd0, 5'd0, 5'd3));
    issue_inst(32'h0000_0002);
    issue_inst(32'h1600_0002);
    issue_inst(enc_3r(OP_ADD_W, 5'd0, 5'd2, 5'd4));
    issue_inst(32'hffff_ffe2);
    issue_inst(enc_ri12(OP_ADDI_W, 12'd1, 5'd2, 5'd5));
    end_test("r0_ill");

    for (int i = 0; i < 200; i++)
    begin
      r1 = $random(seed);
      r2 = $random(seed);
      issue_inst(random_inst(r1, r2));
      if (r1[31:28] == 4'hf)
      begin
        @(negedge clk);
        inst_valid_i = 1'b0; // occasional bubble
      end
    end
    end_test("random");

    $display("all tests: %0d retired, %0d errors", checks, errors);
    if (!timed_out && (errors == 0) && (checks > 0))
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* la_int_pipe.f */
+incdir+common
common/la_pkg.sv
src/dec_stage.sv
src/regfile.sv
src/opnd_stage.sv
src/exec_stage.sv
src/la_int_pipe.sv
dv/wb_checker.sv
dv/tb_la_int_pipe.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module tb_la_int_pipe -f la_int_pipe.f \
		--Mdir obj_dir -o sim_la_int_pipe
	./obj_dir/sim_la_int_pipe > sim.log 2>&1; cat sim.log
	@if grep -q "Test completed successfully" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
